//--- src/arrayPkg.sv
//--------------------------------------
// Array memory shared definitions
// Widths, vector types, action and error codes
//--------------------------------------
package arrayPkg;

  localparam int ARRAY_BITS   = 3;                 // Bits in an array number
  localparam int INDEX_BITS   = 3;                 // Bits in an element index
  localparam int DATA_BITS    = 12;                // Bits in an element
  localparam int ARRAY_COUNT  = 8;                 // Arrays in the heap
  localparam int ARRAY_LENGTH = 8;                 // Elements per array

  typedef logic [ARRAY_BITS-1:0] arrayIdT;         // Array number
  typedef logic [INDEX_BITS-1:0] indexT;           // Element index
  typedef logic [INDEX_BITS:0]   sizeT;            // Array size, 0 to ARRAY_LENGTH
  typedef logic [DATA_BITS-1:0]  dataT;            // Element value
  typedef logic [4:0]            actionT;          // Command action
  typedef logic [3:0]            errorT;           // Command error

  // Action codes ------------------------
  localparam actionT ACT_RESET     = 5'd1;         // Free every array
  localparam actionT ACT_WRITE     = 5'd2;
  localparam actionT ACT_READ      = 5'd3;
  localparam actionT ACT_SIZE      = 5'd4;
  localparam actionT ACT_INDEX     = 5'd7;         // Last match position plus one
  localparam actionT ACT_LESS      = 5'd8;
  localparam actionT ACT_GREATER   = 5'd9;
  localparam actionT ACT_PUSH      = 5'd14;
  localparam actionT ACT_POP       = 5'd15;
  localparam actionT ACT_RESIZE    = 5'd17;
  localparam actionT ACT_ALLOC     = 5'd18;
  localparam actionT ACT_FREE      = 5'd19;
  localparam actionT ACT_ADD       = 5'd20;
  localparam actionT ACT_ADD_AFTER = 5'd21;        // Returns the old value
  localparam actionT ACT_SUBTRACT  = 5'd22;
  localparam actionT ACT_OR        = 5'd28;
  localparam actionT ACT_XOR       = 5'd29;
  localparam actionT ACT_AND       = 5'd30;

  // Error codes -------------------------
  localparam errorT ERR_NONE        = 4'd0;
  localparam errorT ERR_UNALLOCATED = 4'd1;        // Never handed out
  localparam errorT ERR_FREED       = 4'd2;
  localparam errorT ERR_BOUNDS      = 4'd3;
  localparam errorT ERR_EMPTY       = 4'd4;
  localparam errorT ERR_FULL        = 4'd5;
  localparam errorT ERR_NO_MEMORY   = 4'd6;
  localparam errorT ERR_TOO_LARGE   = 4'd7;
  localparam errorT ERR_BAD_ACTION  = 4'd8;

endpackage

//--- src/apbCommandPort.sv
//--------------------------------------
// APB command port
// Latches one command per transfer and returns its response
//--------------------------------------
module apbCommandPort
  import arrayPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    select,
  input  logic    enable,
  input  actionT  action,
  input  arrayIdT array,
  input  indexT   index,
  input  dataT    writeData,
  input  logic    done,
  input  dataT    result,
  input  errorT   error,
  output logic    start,
  output actionT  cmdAction,
  output arrayIdT cmdArray,
  output indexT   cmdIndex,
  output dataT    cmdData,
  output logic    ready,
  output dataT    readData,
  output logic    slverr,
  output errorT   errorCode
);

  typedef enum logic [1:0] {idle, busy, respond} portStateT;

  portStateT state;
  logic      setupCycle;

  assign setupCycle = select && !enable;            // First cycle of a transfer
  assign ready      = (state == respond);           // One cycle only

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= idle;
      start     <= 1'b0;
      slverr    <= 1'b0;
      errorCode <= ERR_NONE;
    end else begin
      start <= 1'b0;
      case (state)
        idle: begin
          if (setupCycle) begin
            state <= busy;
            start <= 1'b1;                          // Engine sees it with the access cycle
          end
        end
        busy: begin
          if (done) begin
            state     <= respond;
            slverr    <= (error != ERR_NONE);
            errorCode <= error;
          end
        end
        respond: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == idle && setupCycle) begin
      cmdAction <= action;
      cmdArray  <= array;
      cmdIndex  <= index;
      cmdData   <= writeData;
    end
    if (state == busy && done && error == ERR_NONE) begin
      readData <= result;                           // Kept from the last good command
    end
  end

endmodule

//--- src/arrayAllocator.sv
//--------------------------------------
// Array allocator
// Hands out array numbers, reusing freed ones first
//--------------------------------------
module arrayAllocator
  import arrayPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    allocRequest,
  input  logic    freeRequest,
  input  logic    clearAll,
  input  arrayIdT queryArray,
  output logic    allocated,
  output logic    everAllocated,
  output arrayIdT allocId,
  output logic    allocAvailable
);

  typedef logic [ARRAY_BITS:0] countT;              // 0 to ARRAY_COUNT

  countT                  highWater;                // Numbers below this were handed out
  countT                  stackTop;                 // Entries on the freed stack
  arrayIdT                freedStack [ARRAY_COUNT];
  logic [ARRAY_COUNT-1:0] allocBits;                // One per array
  logic                   stackEmpty;

  assign stackEmpty     = (stackTop == '0);
  assign allocId        = stackEmpty ? arrayIdT'(highWater)
                                     : freedStack[arrayIdT'(stackTop - 1'b1)];
  assign allocAvailable = !stackEmpty || (highWater < countT'(ARRAY_COUNT));
  assign allocated      = allocBits[queryArray];
  assign everAllocated  = ({1'b0, queryArray} < highWater);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      highWater <= '0;
      stackTop  <= '0;
      allocBits <= '0;
    end else if (clearAll) begin
      highWater <= '0;                              // Every array back to unallocated
      stackTop  <= '0;
      allocBits <= '0;
    end else if (allocRequest) begin
      allocBits[allocId] <= 1'b1;
      if (!stackEmpty) begin
        stackTop <= stackTop - 1'b1;                // Most recently freed first
      end else begin
        highWater <= highWater + 1'b1;
      end
    end else if (freeRequest) begin
      allocBits[queryArray] <= 1'b0;
      stackTop              <= stackTop + 1'b1;
    end
  end

  // Engine rejects double frees, so the stack cannot overflow
  always_ff @(posedge clock) begin
    if (freeRequest && !clearAll) begin
      freedStack[arrayIdT'(stackTop)] <= queryArray;
    end
  end

endmodule

//--- src/elementStore.sv
//--------------------------------------
// Element store
// Element memory and array sizes, updates and scans
//--------------------------------------
module elementStore
  import arrayPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    storeOp,
  input  actionT  cmdAction,
  input  arrayIdT opArray,
  input  indexT   cmdIndex,
  input  dataT    cmdData,
  output sizeT    size,
  output logic    storeDone,
  output dataT    storeResult
);

  dataT  memory [ARRAY_COUNT][ARRAY_LENGTH];
  sizeT  sizes  [ARRAY_COUNT];
  logic  scanning;                                  // Scan in progress
  indexT slot;                                      // Slot visited this cycle
  sizeT  count;                                     // Running scan result
  sizeT  nextCount;
  logic  isScan;
  logic  inRange;
  dataT  slotValue;
  dataT  currentValue;
  indexT lastIndex;
  logic  writeEnable;
  indexT writeIndex;
  dataT  writeValue;
  dataT  opResult;

  assign size      = sizes[opArray];
  assign isScan    = (cmdAction == ACT_INDEX) || (cmdAction == ACT_LESS) ||
                     (cmdAction == ACT_GREATER);
  assign slotValue = memory[opArray][slot];
  assign inRange   = ({1'b0, slot} < size);         // Slots past the size do not count

  always_comb begin
    nextCount = count;
    if (inRange) begin
      case (cmdAction)
        ACT_INDEX:   if (slotValue == cmdData) nextCount = {1'b0, slot} + 1'b1;
        ACT_LESS:    if (slotValue < cmdData) nextCount = count + 1'b1;
        ACT_GREATER: if (slotValue > cmdData) nextCount = count + 1'b1;
        default:     nextCount = count;
      endcase
    end
  end

  // Single-cycle actions ----------------
  always_comb begin
    currentValue = memory[opArray][cmdIndex];
    lastIndex    = indexT'(size - 1'b1);
    writeEnable  = 1'b0;
    writeIndex   = cmdIndex;
    writeValue   = cmdData;
    opResult     = cmdData;
    case (cmdAction)
      ACT_WRITE:     writeEnable = 1'b1;
      ACT_READ:      opResult = currentValue;
      ACT_SIZE:      opResult = dataT'(size);
      ACT_PUSH: begin
        writeEnable = 1'b1;
        writeIndex  = indexT'(size);                // Size is below ARRAY_LENGTH here
      end
      ACT_POP:       opResult = memory[opArray][lastIndex];
      ACT_ALLOC:     opResult = dataT'(opArray);
      ACT_ADD, ACT_ADD_AFTER, ACT_SUBTRACT, ACT_OR, ACT_XOR, ACT_AND: begin
        writeEnable = 1'b1;
        case (cmdAction)
          ACT_SUBTRACT: writeValue = currentValue - cmdData;
          ACT_OR:       writeValue = currentValue | cmdData;
          ACT_XOR:      writeValue = currentValue ^ cmdData;
          ACT_AND:      writeValue = currentValue & cmdData;
          default:      writeValue = currentValue + cmdData;
        endcase
        opResult = (cmdAction == ACT_ADD_AFTER) ? currentValue : writeValue;
      end
      default:       opResult = cmdData;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      storeDone <= 1'b0;
      scanning  <= 1'b0;
      for (int a = 0; a < ARRAY_COUNT; a++) begin
        sizes[a] <= '0;
      end
    end else begin
      storeDone <= 1'b0;
      if (storeOp) begin
        scanning  <= isScan;
        storeDone <= !isScan;
        case (cmdAction)
          ACT_WRITE:  if ({1'b0, cmdIndex} >= size) sizes[opArray] <= {1'b0, cmdIndex} + 1'b1;
          ACT_RESIZE: sizes[opArray] <= sizeT'(cmdData);
          ACT_PUSH:   sizes[opArray] <= size + 1'b1;
          ACT_POP:    sizes[opArray] <= size - 1'b1;
          ACT_ALLOC:  sizes[opArray] <= '0;         // New array starts empty
          default:    sizes[opArray] <= size;
        endcase
      end else if (scanning && slot == indexT'(ARRAY_LENGTH - 1)) begin
        scanning  <= 1'b0;
        storeDone <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (storeOp) begin
      slot        <= '0;
      count       <= '0;
      storeResult <= opResult;
      if (writeEnable) begin
        memory[opArray][writeIndex] <= writeValue;
      end
    end else if (scanning) begin
      slot        <= slot + 1'b1;
      count       <= nextCount;
      storeResult <= dataT'(nextCount);            // Final on the last slot
    end
  end

endmodule

//--- src/arrayEngine.sv
//--------------------------------------
// Array command engine
// Checks legality and sequences allocator and store
//--------------------------------------
module arrayEngine
  import arrayPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    start,
  input  actionT  cmdAction,
  input  arrayIdT cmdArray,
  input  indexT   cmdIndex,
  input  dataT    cmdData,
  input  logic    allocated,
  input  logic    everAllocated,
  input  arrayIdT allocId,
  input  logic    allocAvailable,
  input  sizeT    size,
  input  logic    storeDone,
  input  dataT    storeResult,
  output logic    done,
  output dataT    result,
  output errorT   error,
  output logic    allocRequest,
  output logic    freeRequest,
  output logic    clearAll,
  output logic    storeOp,
  output arrayIdT opArray
);

  typedef enum logic [1:0] {idle, check, waitStore, finish} engineStateT;

  engineStateT state;
  errorT       checkError;
  errorT       errorQ;
  logic        knownAction;
  logic        needsArray;                          // Action names an existing array
  logic        boundsCheck;
  logic        storeAction;
  logic        legal;

  always_comb begin
    knownAction = 1'b1;
    needsArray  = 1'b1;
    boundsCheck = 1'b0;
    storeAction = 1'b1;
    case (cmdAction)
      ACT_RESET: begin
        needsArray  = 1'b0;
        storeAction = 1'b0;
      end
      ACT_ALLOC:  needsArray = 1'b0;                // Store clears the new size
      ACT_FREE:   storeAction = 1'b0;
      ACT_WRITE, ACT_SIZE, ACT_INDEX, ACT_LESS, ACT_GREATER,
      ACT_PUSH, ACT_POP, ACT_RESIZE: storeAction = 1'b1;
      ACT_READ, ACT_ADD, ACT_ADD_AFTER, ACT_SUBTRACT,
      ACT_OR, ACT_XOR, ACT_AND: boundsCheck = 1'b1;
      default: begin
        knownAction = 1'b0;
        needsArray  = 1'b0;
        storeAction = 1'b0;
      end
    endcase

    // First rule that applies wins
    if (!knownAction)                                            checkError = ERR_BAD_ACTION;
    else if (needsArray && !everAllocated)                       checkError = ERR_UNALLOCATED;
    else if (needsArray && !allocated)                           checkError = ERR_FREED;
    else if (boundsCheck && {1'b0, cmdIndex} >= size)            checkError = ERR_BOUNDS;
    else if (cmdAction == ACT_PUSH && size == sizeT'(ARRAY_LENGTH)) checkError = ERR_FULL;
    else if (cmdAction == ACT_POP && size == '0)                 checkError = ERR_EMPTY;
    else if (cmdAction == ACT_RESIZE && cmdData > dataT'(ARRAY_LENGTH))
      checkError = ERR_TOO_LARGE;
    else if (cmdAction == ACT_ALLOC && !allocAvailable)          checkError = ERR_NO_MEMORY;
    else                                                         checkError = ERR_NONE;
  end

  assign legal        = (checkError == ERR_NONE);
  assign opArray      = (cmdAction == ACT_ALLOC) ? allocId : cmdArray;
  assign allocRequest = (state == check) && legal && (cmdAction == ACT_ALLOC);
  assign freeRequest  = (state == check) && legal && (cmdAction == ACT_FREE);
  assign clearAll     = (state == check) && legal && (cmdAction == ACT_RESET);
  assign storeOp      = (state == check) && legal && storeAction;
  assign done         = (state == finish) || (state == waitStore && storeDone);
  assign result       = (state == waitStore) ? storeResult : '0;
  assign error        = errorQ;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= idle;
    end else begin
      case (state)
        idle:      if (start) state <= check;
        check:     state <= (legal && storeAction) ? waitStore : finish;
        waitStore: if (storeDone) state <= idle;    // Scans hold here
        finish:    state <= idle;
        default:   state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == check) begin
      errorQ <= checkError;
    end
  end

endmodule

//--- src/arrayMemory.sv
//--------------------------------------
// Array memory top level
// Heap of fixed-size arrays behind an APB port
//--------------------------------------
module arrayMemory
  import arrayPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    select,
  input  logic    enable,
  input  actionT  action,
  input  arrayIdT array,
  input  indexT   index,
  input  dataT    writeData,
  output logic    ready,
  output dataT    readData,
  output logic    slverr,
  output errorT   errorCode
);

  logic    start, done;                             // Port to engine handshake
  actionT  cmdAction;
  arrayIdT cmdArray, opArray, allocId;
  indexT   cmdIndex;
  dataT    cmdData, result, storeResult;
  errorT   error;
  logic    allocRequest, freeRequest, clearAll;
  logic    allocated, everAllocated, allocAvailable;
  logic    storeOp, storeDone;
  sizeT    size;

  apbCommandPort port_i (
    .clock, .resetN, .select, .enable, .action, .array, .index, .writeData,
    .done, .result, .error, .start, .cmdAction, .cmdArray, .cmdIndex, .cmdData,
    .ready, .readData, .slverr, .errorCode
  );

  arrayEngine engine_i (
    .clock, .resetN, .start, .cmdAction, .cmdArray, .cmdIndex, .cmdData,
    .allocated, .everAllocated, .allocId, .allocAvailable, .size, .storeDone,
    .storeResult, .done, .result, .error, .allocRequest, .freeRequest, .clearAll,
    .storeOp, .opArray
  );

  arrayAllocator allocator_i (
    .clock, .resetN, .allocRequest, .freeRequest, .clearAll,
    .queryArray (cmdArray),                         // Command's array for checks and free
    .allocated, .everAllocated, .allocId, .allocAvailable
  );

  elementStore store_i (
    .clock, .resetN, .storeOp, .cmdAction, .opArray, .cmdIndex, .cmdData,
    .size, .storeDone, .storeResult
  );

endmodule

//--- testbench/arrayMemory_properties.sv
//--------------------------------------
// APB response properties
// Bound to the array memory top level
//--------------------------------------
module arrayMemory_properties
  import arrayPkg::*;
(
  input logic  clock,
  input logic  resetN,
  input logic  select,
  input logic  enable,
  input logic  ready,
  input logic  slverr,
  input errorT errorCode
);

  readyInAccess: assert property (@(posedge clock) disable iff (!resetN)
    ready |-> select && enable)
    else $error("ready raised outside an APB access cycle");

  readySingleCycle: assert property (@(posedge clock) disable iff (!resetN)
    ready |=> !ready)                               // Exactly one cycle per transfer
    else $error("ready held high for more than one cycle");

  slverrMatchesCode: assert property (@(posedge clock) disable iff (!resetN)
    ready |-> slverr == (errorCode != ERR_NONE))
    else $error("slverr does not agree with errorCode");

endmodule

bind arrayMemory arrayMemory_properties properties_i (.*);

//--- testbench/arrayMemoryTb.sv
//--------------------------------------
// Array memory testbench
// Replays golden commands over APB and checks responses
//--------------------------------------
module arrayMemoryTb
  import arrayPkg::*;
();

  localparam int READY_TIMEOUT = 64;               // Cycles to wait for ready

  logic    clock;
  logic    resetN;
  logic    select;
  logic    enable;
  actionT  action;
  arrayIdT array;
  indexT   index;
  dataT    writeData;
  logic    ready;
  dataT    readData;
  logic    slverr;
  errorT   errorCode;

  int      errorCount;
  int      checkCount;
  int      timeoutCount;
  int      commandCount;
  int      lineNumber;                              // Golden file line in progress
  dataT    gotRead;
  errorT   gotError;
  logic    gotSlverr;

  arrayMemory dut_i (.*);

  always #10 clock = ~clock;

  // Checks ------------------------------
  task automatic compareValue(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH at time %0t: line %0d %s expected %h, got %h",
               $time, lineNumber, what, expected, actual);
    end
  endtask

  // One APB transfer, setup then access until ready
  task automatic apbTransfer(input actionT act, input arrayIdT arr, input indexT idx,
                             input dataT data, output logic gotReady);
    int waited;
    waited   = 0;
    gotReady = 1'b0;
    @(negedge clock);
    select    = 1'b1;                               // Setup cycle
    enable    = 1'b0;
    action    = act;
    array     = arr;
    index     = idx;
    writeData = data;
    @(negedge clock);
    enable = 1'b1;
    while (!gotReady && waited < READY_TIMEOUT) begin
      @(negedge clock);
      if (ready) begin
        gotReady  = 1'b1;
        gotRead   = readData;
        gotError  = errorCode;
        gotSlverr = slverr;
      end else begin
        waited++;
      end
    end
    if (gotReady) begin
      @(negedge clock);                             // Let the ready edge complete
    end
    select = 1'b0;
    enable = 1'b0;
  endtask

  // Main sequence -----------------------
  initial begin
    int               fd;
    int               fieldCount;
    string            lineText;
    logic [15:0]      actVal;
    logic [15:0]      arrVal;
    logic [15:0]      idxVal;
    logic [15:0]      dataVal;
    logic [15:0]      checkFlag;
    logic [15:0]      expRead;
    logic [15:0]      expError;
    logic             gotReady;

    clock        = 1'b0;
    resetN       = 1'b0;
    select       = 1'b0;
    enable       = 1'b0;
    action       = '0;
    array        = '0;
    index        = '0;
    writeData    = '0;
    errorCount   = 0;
    checkCount   = 0;
    timeoutCount = 0;
    commandCount = 0;
    lineNumber   = 0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;

    fd = $fopen("testbench/arrayGolden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file testbench/arrayGolden.txt");
      errorCount++;
    end else begin
      while (!$feof(fd) && timeoutCount == 0) begin
        lineText = "";
        if ($fgets(lineText, fd) != 0) begin
          lineNumber++;
          fieldCount = $sscanf(lineText, "%h %h %h %h %h %h %h", actVal, arrVal,
                               idxVal, dataVal, checkFlag, expRead, expError);
          if (fieldCount == 7) begin                // Comment lines are skipped
            commandCount++;
            apbTransfer(actionT'(actVal), arrayIdT'(arrVal), indexT'(idxVal),
                        dataT'(dataVal), gotReady);
            if (!gotReady) begin
              $display("Timeout: ready never came for golden line %0d", lineNumber);
              timeoutCount++;
            end else begin
              compareValue("errorCode", expError, 16'(gotError));
              compareValue("slverr", 16'(expError != 16'(ERR_NONE)), 16'(gotSlverr));
              if (expError == 16'(ERR_NONE) && checkFlag != 0) begin
                compareValue("readData", expRead, 16'(gotRead));
              end
            end
          end
        end
      end
      $fclose(fd);
      if (commandCount == 0) begin
        $display("The golden file held no commands");
        errorCount++;
      end
    end

    $display("Commands: %0d, checks: %0d, errors: %0d, timeouts: %0d",
             commandCount, checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
src/arrayPkg.sv
src/apbCommandPort.sv
src/arrayAllocator.sv
src/elementStore.sv
src/arrayEngine.sv
src/arrayMemory.sv
testbench/arrayMemory_properties.sv
testbench/arrayMemoryTb.sv

//--- Makefile
# Verilator build and run for the array memory testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module arrayMemoryTb \
	  -f build.f --Mdir $(OBJ_DIR) -o VarrayMemoryTb

run: compile
	./$(OBJ_DIR)/VarrayMemoryTb | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/arrayGolden.txt
# action array index writeData checkRead expectedRead expectedError, all hex
# checkRead 0 leaves readData unchecked for actions without a defined result
03 0 0 000 0 000 1
01 0 0 000 0 000 0
12 0 0 000 1 000 0
12 0 0 000 1 001 0
12 0 0 000 1 002 0
04 5 0 000 0 000 1
# element access on array 0
02 0 2 0AB 1 0AB 0
03 0 2 000 1 0AB 0
04 0 0 000 1 003 0
03 0 3 000 0 000 3
11 0 0 009 0 000 7
# scans on array 1 holding 10 20 30
02 1 0 00A 1 00A 0
02 1 1 014 1 014 0
02 1 2 01E 1 01E 0
09 1 0 00F 1 002 0
08 1 0 00F 1 001 0
07 1 0 014 1 002 0
07 1 0 063 1 000 0
02 1 3 014 1 014 0
07 1 0 014 1 004 0
# stack actions on array 2
0E 2 0 111 0 000 0
0E 2 0 222 0 000 0
0F 2 0 000 1 222 0
0F 2 0 000 1 111 0
0F 2 0 000 0 000 4
11 2 0 008 0 000 0
0E 2 0 333 0 000 5
# arithmetic on array 0 element 2
14 0 2 FFF 1 0AA 0
15 0 2 010 1 0AA 0
16 0 2 0C0 1 FFA 0
1C 0 2 005 1 FFF 0
1D 0 2 0F0 1 F0F 0
1E 0 2 0FF 1 00F 0
# freed arrays, unknown action and running out of arrays
13 1 0 000 0 000 0
03 1 0 000 0 000 2
13 1 0 000 0 000 2
05 0 0 000 0 000 8
12 0 0 000 1 001 0
12 0 0 000 1 003 0
12 0 0 000 1 004 0
12 0 0 000 1 005 0
12 0 0 000 1 006 0
12 0 0 000 1 007 0
12 0 0 000 0 000 6
